// ==== verilog/hbus_consts.svh ====
// HyperBus timing constants, counter width and AXI4-Lite bus widths
`ifndef HBUS_CONSTS_SVH
`define HBUS_CONSTS_SVH

// Initial access latency in clk cycles (1x)
`define HBUS_TACC 7

// Cycles the memory stays in reset after rst drops
`define HBUS_RESET_COUNT 4

// Cycles a read waits for each RWDS strobe
`define HBUS_TIMEOUT 16

// Minimum CS# high time between transactions
`define HBUS_IDLE_GAP 3

// Shared down-counter, wide enough for 2x latency and the timeout
`define HBUS_CNT_W 5

// AXI4-Lite
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

`endif

// ==== verilog/hbus_pkg.sv ====
// Shared types: bus vectors, controller request and response, controller states
`default_nettype none

`include "hbus_consts.svh"

package hbus_pkg;

    // One DQ beat, stands for a full DDR pair
    typedef logic [15:0] half_t;

    typedef logic [`AXIL_DATA_W-1:0] word_t;

    // Halfword address, even for every word access
    typedef logic [29:0] hw_addr_t;

    // Command/address, sent as three beats
    typedef logic [47:0] ca_t;

    typedef logic [`HBUS_CNT_W-1:0] cnt_t;

    typedef struct packed {
        logic     write;
        logic     reg_space;
        hw_addr_t hw_addr;
        word_t    wdata;
    } hbus_req_t;

    typedef struct packed {
        word_t rdata;
        logic  error;
    } hbus_rsp_t;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        COMMAND,
        LATENCY,
        READ,
        WRITE,
        GAP
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/axil_slave_port.sv ====
// AXI4-Lite slave port turning one read or write into a controller request
`timescale 1ns/1ns
`default_nettype none

`include "hbus_consts.svh"

module axil_slave_port
    import hbus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`AXIL_ADDR_W-1:0] s_awaddr_i,
    input  logic                    s_awvalid_i,
    output logic                    s_awready_o,
    input  logic [`AXIL_DATA_W-1:0] s_wdata_i,
    input  logic                    s_wvalid_i,
    output logic                    s_wready_o,
    output logic [1:0]              s_bresp_o,
    output logic                    s_bvalid_o,
    input  logic                    s_bready_i,
    input  logic [`AXIL_ADDR_W-1:0] s_araddr_i,
    input  logic                    s_arvalid_i,
    output logic                    s_arready_o,
    output logic [`AXIL_DATA_W-1:0] s_rdata_o,
    output logic [1:0]              s_rresp_o,
    output logic                    s_rvalid_o,
    input  logic                    s_rready_i,
    output logic                    req_valid_o,
    output hbus_req_t               req_o,
    input  logic                    done_i,
    input  hbus_rsp_t               rsp_i
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_BUSY,
        P_RESP
    } port_state_t;

    port_state_t state;
    hbus_req_t   req_q;
    hbus_rsp_t   rsp_q;
    logic        take_rd;
    logic        take_wr;
    logic        rsp_taken;
    logic [1:0]  resp;

    // A read wins when both arrive together
    assign take_rd = (state == P_IDLE) && s_arvalid_i;
    assign take_wr = (state == P_IDLE) && s_awvalid_i && s_wvalid_i && !s_arvalid_i;

    assign s_arready_o = take_rd;
    assign s_awready_o = take_wr;
    assign s_wready_o  = take_wr;

    assign req_valid_o = (state == P_BUSY);
    assign req_o       = req_q;

    // SLVERR after a controller timeout
    assign resp       = rsp_q.error ? 2'b10 : 2'b00;
    assign s_bresp_o  = resp;
    assign s_rresp_o  = resp;
    assign s_rdata_o  = rsp_q.rdata;
    assign s_bvalid_o = (state == P_RESP) && req_q.write;
    assign s_rvalid_o = (state == P_RESP) && !req_q.write;
    assign rsp_taken  = req_q.write ? s_bready_i : s_rready_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= P_IDLE;
        end else begin
            case (state)
                P_IDLE: begin
                    if (take_rd || take_wr) begin
                        state <= P_BUSY;
                    end
                end
                P_BUSY: begin
                    if (done_i) begin
                        state <= P_RESP;
                    end
                end
                P_RESP: begin
                    // Held here under back-pressure
                    if (rsp_taken) begin
                        state <= P_IDLE;
                    end
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    // Bit 31 picks register space, bits 30:2 give the word
    always_ff @(posedge clk) begin
        if (take_rd) begin
            req_q.write     <= 1'b0;
            req_q.reg_space <= s_araddr_i[`AXIL_ADDR_W-1];
            req_q.hw_addr   <= {s_araddr_i[`AXIL_ADDR_W-2:2], 1'b0};
        end else if (take_wr) begin
            req_q.write     <= 1'b1;
            req_q.reg_space <= s_awaddr_i[`AXIL_ADDR_W-1];
            req_q.hw_addr   <= {s_awaddr_i[`AXIL_ADDR_W-2:2], 1'b0};
            req_q.wdata     <= s_wdata_i;
        end
        if ((state == P_BUSY) && done_i) begin
            rsp_q <= rsp_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hbus_arbiter.sv ====
// Round-robin arbiter sharing one HyperBus controller between two ports
`timescale 1ns/1ns
`default_nettype none

module hbus_arbiter
    import hbus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req0_valid_i,
    input  hbus_req_t req0_i,
    output logic      done0_o,
    input  logic      req1_valid_i,
    input  hbus_req_t req1_i,
    output logic      done1_o,
    output hbus_rsp_t rsp_o,
    output logic      ctrl_req_valid_o,
    output hbus_req_t ctrl_req_o,
    input  logic      ctrl_done_i,
    input  hbus_rsp_t ctrl_rsp_i
);

    logic busy;
    // Current owner, and the last winner once the grant is released
    logic owner;
    logic pick;

    // Alternate when both ask, otherwise take whichever asks
    assign pick = (req0_valid_i && req1_valid_i) ? !owner : req1_valid_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            // Port 0 goes first after reset
            owner <= 1'b1;
        end else if (!busy) begin
            if (req0_valid_i || req1_valid_i) begin
                busy  <= 1'b1;
                owner <= pick;
            end
        end else if (ctrl_done_i) begin
            busy <= 1'b0;
        end
    end

    assign ctrl_req_valid_o = busy && (owner ? req1_valid_i : req0_valid_i);
    assign ctrl_req_o       = owner ? req1_i : req0_i;

    // Only the owner sees done, so the response can be shared
    assign done0_o = busy && !owner && ctrl_done_i;
    assign done1_o = busy && owner && ctrl_done_i;
    assign rsp_o   = ctrl_rsp_i;

endmodule

`default_nettype wire

// ==== verilog/hbus_ctrl.sv ====
// HyperBus controller FSM: memory reset, command, latency, data beats, read timeout
`timescale 1ns/1ns
`default_nettype none

`include "hbus_consts.svh"

module hbus_ctrl
    import hbus_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid_i,
    input  hbus_req_t req_i,
    output logic      done_o,
    output hbus_rsp_t rsp_o,
    output logic      hbus_ck_o,
    output logic      hbus_csn_o,
    output logic      hbus_rstn_o,
    output half_t     hbus_dq_o,
    output logic      hbus_dq_oe_o,
    input  half_t     hbus_dq_i,
    output logic      hbus_rwds_o,
    output logic      hbus_rwds_oe_o,
    input  logic      hbus_rwds_i
);

    ctrl_state_t state;
    // One counter for reset, command, latency, timeout and gap
    cnt_t        cnt;
    ca_t         ca;
    ca_t         ca_next;
    logic        clk_oe;
    logic        beat;
    logic        is_write;
    word_t       wdata_q;
    word_t       rdata_q;
    logic        err_q;
    logic        done_q;
    logic        accept;
    logic        rd_strobe;
    logic        rd_timeout;
    logic        finish;

    // R/W#, address space, linear burst, then the split halfword address
    assign ca_next = {!req_i.write, req_i.reg_space, 1'b1,
                      2'b00, req_i.hw_addr[29:3],
                      13'd0, req_i.hw_addr[2:0]};

    assign accept     = (state == IDLE) && req_valid_i;
    assign rd_strobe  = (state == READ) && hbus_rwds_i;
    assign rd_timeout = (state == READ) && !hbus_rwds_i && (cnt == '0);
    assign finish     = ((state == WRITE) && beat) || (rd_strobe && beat) || rd_timeout;

    assign hbus_rstn_o = (state != RESET);
    assign hbus_csn_o  = (state == RESET) || (state == IDLE) || (state == GAP);
    assign hbus_ck_o   = clk && clk_oe;

    assign hbus_dq_oe_o = (state == COMMAND) || (state == WRITE);
    // Low half first, it belongs at the even halfword
    assign hbus_dq_o    = (state == WRITE) ? (beat ? wdata_q[31:16] : wdata_q[15:0])
                                           : ca[47:32];

    // RWDS low during data means no byte is masked
    assign hbus_rwds_oe_o = (state == WRITE);
    assign hbus_rwds_o    = 1'b0;

    assign done_o = done_q;
    assign rsp_o  = '{rdata: rdata_q, error: err_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= RESET;
            cnt    <= cnt_t'(`HBUS_RESET_COUNT - 1);
            clk_oe <= 1'b0;
            beat   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                RESET: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        // Three beats of command/address
                        cnt    <= cnt_t'(2);
                        clk_oe <= 1'b1;
                        state  <= COMMAND;
                    end
                end
                COMMAND: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        // Memory holds RWDS high to ask for 2x latency
                        if (hbus_rwds_i) begin
                            cnt <= cnt_t'(2 * `HBUS_TACC - 1);
                        end else begin
                            cnt <= cnt_t'(`HBUS_TACC - 1);
                        end
                        state <= LATENCY;
                    end
                end
                LATENCY: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        beat  <= 1'b0;
                        cnt   <= cnt_t'(`HBUS_TIMEOUT - 1);
                        state <= is_write ? WRITE : READ;
                    end
                end
                WRITE: begin
                    beat <= !beat;
                end
                READ: begin
                    cnt <= cnt - 1'b1;
                    // Timeout restarts for each beat
                    if (rd_strobe) begin
                        beat <= 1'b1;
                        cnt  <= cnt_t'(`HBUS_TIMEOUT - 1);
                    end
                end
                GAP: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    cnt   <= cnt_t'(`HBUS_RESET_COUNT - 1);
                    state <= RESET;
                end
            endcase

            // Last beat or timeout, then CS# goes high
            if (finish) begin
                done_q <= 1'b1;
                clk_oe <= 1'b0;
                cnt    <= cnt_t'(`HBUS_IDLE_GAP - 1);
                state  <= GAP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ca       <= ca_next;
            is_write <= req_i.write;
            wdata_q  <= req_i.wdata;
        end else if (state == COMMAND) begin
            ca <= ca << 16;
        end
        if (rd_strobe) begin
            if (beat) begin
                rdata_q[31:16] <= hbus_dq_i;
            end else begin
                rdata_q[15:0] <= hbus_dq_i;
            end
        end
        if (finish) begin
            err_q <= rd_timeout;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hbus_top.sv ====
// Top level: two AXI4-Lite ports, round-robin arbiter and HyperBus controller
`timescale 1ns/1ns
`default_nettype none

`include "hbus_consts.svh"

module hbus_top
    import hbus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`AXIL_ADDR_W-1:0] s0_awaddr_i,
    input  logic                    s0_awvalid_i,
    output logic                    s0_awready_o,
    input  logic [`AXIL_DATA_W-1:0] s0_wdata_i,
    input  logic                    s0_wvalid_i,
    output logic                    s0_wready_o,
    output logic [1:0]              s0_bresp_o,
    output logic                    s0_bvalid_o,
    input  logic                    s0_bready_i,
    input  logic [`AXIL_ADDR_W-1:0] s0_araddr_i,
    input  logic                    s0_arvalid_i,
    output logic                    s0_arready_o,
    output logic [`AXIL_DATA_W-1:0] s0_rdata_o,
    output logic [1:0]              s0_rresp_o,
    output logic                    s0_rvalid_o,
    input  logic                    s0_rready_i,
    input  logic [`AXIL_ADDR_W-1:0] s1_awaddr_i,
    input  logic                    s1_awvalid_i,
    output logic                    s1_awready_o,
    input  logic [`AXIL_DATA_W-1:0] s1_wdata_i,
    input  logic                    s1_wvalid_i,
    output logic                    s1_wready_o,
    output logic [1:0]              s1_bresp_o,
    output logic                    s1_bvalid_o,
    input  logic                    s1_bready_i,
    input  logic [`AXIL_ADDR_W-1:0] s1_araddr_i,
    input  logic                    s1_arvalid_i,
    output logic                    s1_arready_o,
    output logic [`AXIL_DATA_W-1:0] s1_rdata_o,
    output logic [1:0]              s1_rresp_o,
    output logic                    s1_rvalid_o,
    input  logic                    s1_rready_i,
    output logic                    hbus_ck_o,
    output logic                    hbus_csn_o,
    output logic                    hbus_rstn_o,
    output half_t                   hbus_dq_o,
    output logic                    hbus_dq_oe_o,
    input  half_t                   hbus_dq_i,
    output logic                    hbus_rwds_o,
    output logic                    hbus_rwds_oe_o,
    input  logic                    hbus_rwds_i
);

    logic      req0_valid;
    hbus_req_t req0;
    logic      done0;
    logic      req1_valid;
    hbus_req_t req1;
    logic      done1;
    hbus_rsp_t rsp;
    logic      ctrl_req_valid;
    hbus_req_t ctrl_req;
    logic      ctrl_done;
    hbus_rsp_t ctrl_rsp;

    axil_slave_port u_port0 (
        .clk         (clk),
        .rst         (rst),
        .s_awaddr_i  (s0_awaddr_i),  .s_awvalid_i (s0_awvalid_i),
        .s_awready_o (s0_awready_o),
        .s_wdata_i   (s0_wdata_i),   .s_wvalid_i  (s0_wvalid_i),
        .s_wready_o  (s0_wready_o),
        .s_bresp_o   (s0_bresp_o),   .s_bvalid_o  (s0_bvalid_o),
        .s_bready_i  (s0_bready_i),
        .s_araddr_i  (s0_araddr_i),  .s_arvalid_i (s0_arvalid_i),
        .s_arready_o (s0_arready_o),
        .s_rdata_o   (s0_rdata_o),   .s_rresp_o   (s0_rresp_o),
        .s_rvalid_o  (s0_rvalid_o),  .s_rready_i  (s0_rready_i),
        .req_valid_o (req0_valid),   .req_o       (req0),
        .done_i      (done0),        .rsp_i       (rsp)
    );

    axil_slave_port u_port1 (
        .clk         (clk),
        .rst         (rst),
        .s_awaddr_i  (s1_awaddr_i),  .s_awvalid_i (s1_awvalid_i),
        .s_awready_o (s1_awready_o),
        .s_wdata_i   (s1_wdata_i),   .s_wvalid_i  (s1_wvalid_i),
        .s_wready_o  (s1_wready_o),
        .s_bresp_o   (s1_bresp_o),   .s_bvalid_o  (s1_bvalid_o),
        .s_bready_i  (s1_bready_i),
        .s_araddr_i  (s1_araddr_i),  .s_arvalid_i (s1_arvalid_i),
        .s_arready_o (s1_arready_o),
        .s_rdata_o   (s1_rdata_o),   .s_rresp_o   (s1_rresp_o),
        .s_rvalid_o  (s1_rvalid_o),  .s_rready_i  (s1_rready_i),
        .req_valid_o (req1_valid),   .req_o       (req1),
        .done_i      (done1),        .rsp_i       (rsp)
    );

    hbus_arbiter u_arb (
        .clk              (clk),
        .rst              (rst),
        .req0_valid_i     (req0_valid),
        .req0_i           (req0),
        .done0_o          (done0),
        .req1_valid_i     (req1_valid),
        .req1_i           (req1),
        .done1_o          (done1),
        .rsp_o            (rsp),
        .ctrl_req_valid_o (ctrl_req_valid),
        .ctrl_req_o       (ctrl_req),
        .ctrl_done_i      (ctrl_done),
        .ctrl_rsp_i       (ctrl_rsp)
    );

    hbus_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (ctrl_req_valid),
        .req_i          (ctrl_req),
        .done_o         (ctrl_done),
        .rsp_o          (ctrl_rsp),
        .hbus_ck_o      (hbus_ck_o),
        .hbus_csn_o     (hbus_csn_o),
        .hbus_rstn_o    (hbus_rstn_o),
        .hbus_dq_o      (hbus_dq_o),
        .hbus_dq_oe_o   (hbus_dq_oe_o),
        .hbus_dq_i      (hbus_dq_i),
        .hbus_rwds_o    (hbus_rwds_o),
        .hbus_rwds_oe_o (hbus_rwds_oe_o),
        .hbus_rwds_i    (hbus_rwds_i)
    );

endmodule

`default_nettype wire

// ==== verification/hyperram_model.sv ====
// Behavioral HyperRAM with a halfword array, 2x latency request and silent register space
`timescale 1ns/1ns
`default_nettype none

`include "hbus_consts.svh"

module hyperram_model
    import hbus_pkg::*;
(
    input  logic  clk,
    input  logic  rstn_i,
    input  logic  csn_i,
    input  half_t dq_i,
    input  logic  dq_oe_i,
    output half_t dq_o,
    output logic  rwds_o
);

    half_t      mem [0:255];
    int         k;
    int         data_k;
    half_t      beat0;
    half_t      beat1;
    logic [7:0] idx;
    logic       is_read;
    logic       is_reg;

    // Pattern built from the whole index so stale reads stand out
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), ~8'(i)};
        end
        k      = 0;
        dq_o   = '0;
        rwds_o = 1'b0;
    end

    // Command beat 0 carries R/W# and the address space
    assign is_read = beat0[15];
    assign is_reg  = beat0[14];

    // hw_addr bit 7 sits at CA bit 20, beat 1 bit 4
    assign data_k = 3 + (beat1[4] ? 2 * `HBUS_TACC : `HBUS_TACC);

    // Sampled and driven on the falling edge, stable at the controller's rising edge
    always @(negedge clk) begin
        if (!rstn_i || csn_i) begin
            k      <= 0;
            dq_o   <= '0;
            rwds_o <= 1'b0;
        end else begin
            k      <= k + 1;
            dq_o   <= '0;
            rwds_o <= 1'b0;
            if (k == 0) begin
                beat0 <= dq_i;
            end
            if (k == 1) begin
                beat1  <= dq_i;
                rwds_o <= dq_i[4];
            end
            if (k == 2) begin
                // Index is hw_addr[7:0]
                idx    <= {beat1[4:0], dq_i[2:0]};
                rwds_o <= beat1[4];
            end
            if (k >= 3 && is_read && !is_reg) begin
                if (k == data_k) begin
                    rwds_o <= 1'b1;
                    dq_o   <= mem[idx];
                end
                if (k == data_k + 1) begin
                    rwds_o <= 1'b1;
                    dq_o   <= mem[{idx[7:1], 1'b1}];
                end
            end
            if (k >= 3 && !is_read && !is_reg && dq_oe_i) begin
                if (k == data_k) begin
                    mem[idx] <= dq_i;
                end
                if (k == data_k + 1) begin
                    mem[{idx[7:1], 1'b1}] <= dq_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/hbus_assert.sv ====
// Bound checks on HyperBus chip select, output enables and the done pulse
`timescale 1ns/1ns
`default_nettype none

`include "hbus_consts.svh"

module hbus_assert (
    input logic clk,
    input logic rst,
    input logic hbus_csn_o,
    input logic hbus_dq_oe_o,
    input logic hbus_rwds_oe_o,
    input logic done_o
);

    // CS# high for at least the idle gap once a transaction ends
    csn_gap: assert property (@(posedge clk) disable iff (rst)
        $rose(hbus_csn_o) |-> hbus_csn_o [*`HBUS_IDLE_GAP])
        else $error("CS# high time shorter than the idle gap");

    // No pin driven while the memory is deselected
    idle_bus: assert property (@(posedge clk) disable iff (rst)
        hbus_csn_o |-> (!hbus_dq_oe_o && !hbus_rwds_oe_o))
        else $error("DQ or RWDS driven with CS# high");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_o |=> !done_o)
        else $error("done held for more than one cycle");

endmodule

bind hbus_ctrl hbus_assert u_assert (.*);

`default_nettype wire

// ==== verification/hbus_tb.sv ====
// Testbench: clock, reset, AXI4-Lite drivers, stimulus table, checks and timeout
`timescale 1ns/1ns
`default_nettype none

`include "hbus_consts.svh"

module hbus_tb
    import hbus_pkg::*;
;

    localparam int NUM_TESTS   = 15;
    localparam int CYCLE_LIMIT = 400 * NUM_TESTS;

    logic        clk;
    logic        rst;
    logic [31:0] awaddr [2];
    logic        awvalid [2];
    logic        awready [2];
    word_t       wdata [2];
    logic        wvalid [2];
    logic        wready [2];
    logic [1:0]  bresp [2];
    logic        bvalid [2];
    logic        bready [2];
    logic [31:0] araddr [2];
    logic        arvalid [2];
    logic        arready [2];
    word_t       rdata [2];
    logic [1:0]  rresp [2];
    logic        rvalid [2];
    logic        rready [2];
    logic        hbus_ck;
    logic        hbus_csn;
    logic        hbus_rstn;
    half_t       hbus_dq_out;
    logic        hbus_dq_oe;
    half_t       ram_dq;
    logic        hbus_rwds_out;
    logic        hbus_rwds_oe;
    logic        ram_rwds;

    // Stimulus table
    int          port_tab [NUM_TESTS];
    logic        write_tab [NUM_TESTS];
    logic [31:0] addr_tab [NUM_TESTS];
    word_t       wdata_tab [NUM_TESTS];
    word_t       rdata_tab [NUM_TESTS];
    logic [1:0]  resp_tab [NUM_TESTS];
    int          hold_tab [NUM_TESTS];
    logic        pair_tab [NUM_TESTS];
    int          n_entries;

    logic [31:0] lfsr;
    int          cycles;
    int          passed;
    int          failed;
    int          pin_errors;
    int          t;
    word_t       d [7];

    hbus_top u_dut (
        .clk (clk), .rst (rst),
        .s0_awaddr_i (awaddr[0]), .s0_awvalid_i (awvalid[0]), .s0_awready_o (awready[0]),
        .s0_wdata_i (wdata[0]), .s0_wvalid_i (wvalid[0]), .s0_wready_o (wready[0]),
        .s0_bresp_o (bresp[0]), .s0_bvalid_o (bvalid[0]), .s0_bready_i (bready[0]),
        .s0_araddr_i (araddr[0]), .s0_arvalid_i (arvalid[0]), .s0_arready_o (arready[0]),
        .s0_rdata_o (rdata[0]), .s0_rresp_o (rresp[0]), .s0_rvalid_o (rvalid[0]),
        .s0_rready_i (rready[0]),
        .s1_awaddr_i (awaddr[1]), .s1_awvalid_i (awvalid[1]), .s1_awready_o (awready[1]),
        .s1_wdata_i (wdata[1]), .s1_wvalid_i (wvalid[1]), .s1_wready_o (wready[1]),
        .s1_bresp_o (bresp[1]), .s1_bvalid_o (bvalid[1]), .s1_bready_i (bready[1]),
        .s1_araddr_i (araddr[1]), .s1_arvalid_i (arvalid[1]), .s1_arready_o (arready[1]),
        .s1_rdata_o (rdata[1]), .s1_rresp_o (rresp[1]), .s1_rvalid_o (rvalid[1]),
        .s1_rready_i (rready[1]),
        .hbus_ck_o (hbus_ck), .hbus_csn_o (hbus_csn), .hbus_rstn_o (hbus_rstn),
        .hbus_dq_o (hbus_dq_out), .hbus_dq_oe_o (hbus_dq_oe), .hbus_dq_i (ram_dq),
        .hbus_rwds_o (hbus_rwds_out), .hbus_rwds_oe_o (hbus_rwds_oe),
        .hbus_rwds_i (ram_rwds)
    );

    hyperram_model u_ram (
        .clk     (clk),
        .rstn_i  (hbus_rstn),
        .csn_i   (hbus_csn),
        .dq_i    (hbus_dq_out),
        .dq_oe_i (hbus_dq_oe),
        .dq_o    (ram_dq),
        .rwds_o  (ram_rwds)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Memory clock only runs with CS# low and RWDS stays low whenever driven
    always @(posedge clk) begin
        #2;
        assert (hbus_ck == !hbus_csn) else begin
            $display("error at %0t: hbus_ck_o expected %0b got %0b", $time, !hbus_csn,
                     hbus_ck);
            pin_errors++;
        end
        if (hbus_rwds_oe) begin
            assert (hbus_rwds_out == 1'b0) else begin
                $display("error at %0t: hbus_rwds_o expected 0 got %0b", $time,
                         hbus_rwds_out);
                pin_errors++;
            end
        end
    end

    // Galois LFSR stepped once per bit
    task automatic next_word(output word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w    = {lfsr[0], w[31:1]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    task automatic add_entry(input int p, input logic w, input logic [31:0] a,
                             input word_t wd, input word_t rd, input logic [1:0] rs,
                             input int hold, input logic pair);
        port_tab[n_entries]  = p;
        write_tab[n_entries] = w;
        addr_tab[n_entries]  = a;
        wdata_tab[n_entries] = wd;
        rdata_tab[n_entries] = rd;
        resp_tab[n_entries]  = rs;
        hold_tab[n_entries]  = hold;
        pair_tab[n_entries]  = pair;
        n_entries++;
    endtask

    // Byte address bit 8 is hw_addr bit 7, which asks for 2x latency
    task automatic build_table();
        for (int i = 0; i < 7; i++) begin
            next_word(d[i]);
        end
        n_entries = 0;
        add_entry(0, 1, 32'h0000_0010, d[0], '0, 2'b00, 0, 0);
        add_entry(0, 0, 32'h0000_0010, '0, d[0], 2'b00, 0, 0);
        add_entry(0, 1, 32'h0000_0120, d[1], '0, 2'b00, 0, 0);
        add_entry(0, 0, 32'h0000_0120, '0, d[1], 2'b00, 0, 0);
        add_entry(1, 1, 32'h0000_0040, d[2], '0, 2'b00, 0, 0);
        add_entry(1, 1, 32'h0000_01a8, d[3], '0, 2'b00, 0, 0);
        add_entry(0, 0, 32'h0000_0040, '0, d[2], 2'b00, 0, 0);
        add_entry(0, 0, 32'h0000_01a8, '0, d[3], 2'b00, 0, 0);
        // Register space never answers
        add_entry(0, 0, 32'h8000_0010, '0, '0, 2'b10, 0, 0);
        add_entry(0, 0, 32'h0000_0010, '0, d[0], 2'b00, 5, 0);
        add_entry(1, 1, 32'h0000_00c4, d[4], '0, 2'b00, 4, 0);
        add_entry(0, 1, 32'h0000_0060, d[5], '0, 2'b00, 0, 1);
        add_entry(1, 1, 32'h0000_0160, d[6], '0, 2'b00, 0, 0);
        add_entry(0, 0, 32'h0000_0160, '0, d[6], 2'b00, 0, 1);
        add_entry(1, 0, 32'h0000_00c4, '0, d[4], 2'b00, 0, 0);
    endtask

    task automatic run_access(input int e);
        int          p;
        logic        w;
        logic        ok;
        logic        accepted;
        logic [1:0]  got_resp;
        word_t       got_data;
        p  = port_tab[e];
        w  = write_tab[e];
        ok = 1'b1;
        if (w) begin
            awaddr[p]  = addr_tab[e];
            wdata[p]   = wdata_tab[e];
            awvalid[p] = 1'b1;
            wvalid[p]  = 1'b1;
        end else begin
            araddr[p]  = addr_tab[e];
            arvalid[p] = 1'b1;
        end
        // Ready is looked at mid-cycle, before the edge that takes the address
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = w ? (awready[p] && wready[p]) : arready[p];
            @(posedge clk);
            #1;
        end
        awvalid[p] = 1'b0;
        wvalid[p]  = 1'b0;
        arvalid[p] = 1'b0;
        while (!(w ? bvalid[p] : rvalid[p])) begin
            @(posedge clk);
            #1;
        end
        got_resp = w ? bresp[p] : rresp[p];
        got_data = rdata[p];
        // Response must hold steady under back-pressure
        for (int i = 0; i < hold_tab[e]; i++) begin
            @(posedge clk);
            #1;
            assert ((w ? bvalid[p] : rvalid[p]) && (w ? bresp[p] : rresp[p]) == got_resp
                    && (w || rdata[p] == got_data)) else begin
                $display("response on port %0d changed before it was taken", p);
                ok = 1'b0;
            end
        end
        if (w) begin
            bready[p] = 1'b1;
        end else begin
            rready[p] = 1'b1;
        end
        @(posedge clk);
        #1;
        bready[p] = 1'b0;
        rready[p] = 1'b0;
        assert (got_resp == resp_tab[e]) else begin
            $display("error at %0t: s%0d_%s expected %0d got %0d", $time, p,
                     w ? "bresp_o" : "rresp_o", resp_tab[e], got_resp);
            ok = 1'b0;
        end
        if (!w && resp_tab[e] == 2'b00) begin
            assert (got_data == rdata_tab[e]) else begin
                $display("error at %0t: s%0d_rdata_o expected %08h got %08h", $time, p,
                         rdata_tab[e], got_data);
                ok = 1'b0;
            end
        end
        if (ok) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d: port %0d %s addr %08h %s", e, p, w ? "write" : "read",
                 addr_tab[e], ok ? "ok" : "failed");
    endtask

    initial begin
        rst        = 1'b1;
        cycles     = 0;
        passed     = 0;
        failed     = 0;
        pin_errors = 0;
        lfsr       = 32'h864c;
        for (int i = 0; i < 2; i++) begin
            awaddr[i]  = '0;
            awvalid[i] = 1'b0;
            wdata[i]   = '0;
            wvalid[i]  = 1'b0;
            bready[i]  = 1'b0;
            araddr[i]  = '0;
            arvalid[i] = 1'b0;
            rready[i]  = 1'b0;
        end
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (`HBUS_RESET_COUNT + 2) @(posedge clk);
        #1;
        assert (hbus_rstn == 1'b1) else begin
            $display("memory reset still active after the reset count");
            failed++;
        end
        t = 0;
        while (t < n_entries) begin
            if (pair_tab[t]) begin
                fork
                    run_access(t);
                    run_access(t + 1);
                join
                t += 2;
            end else begin
                run_access(t);
                t++;
            end
        end
        $display("%0d tests passed, %0d failed, %0d pin errors", passed, failed, pin_errors);
        if (failed == 0 && pin_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/hbus_pkg.sv
verilog/axil_slave_port.sv
verilog/hbus_arbiter.sv
verilog/hbus_ctrl.sv
verilog/hbus_top.sv
verification/hyperram_model.sv
verification/hbus_assert.sv
verification/hbus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the HyperRAM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module hbus_tb -o sim_hbus

./obj_dir/sim_hbus | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    exit 1
fi
exit 0
